// ==== sim.f ====
+incdir+testbench
source/cluster_mem_pkg.sv
source/mem_fifo.sv
source/core_req_merge.sv
source/dram_req_arb.sv
source/dram_rsp_route.sv
source/snoop_fwd.sv
source/cluster_mem.sv
testbench/tb_cluster_mem.sv

// ==== Makefile ====
RTL = source/cluster_mem_pkg.sv source/mem_fifo.sv source/core_req_merge.sv \
      source/dram_req_arb.sv source/dram_rsp_route.sv source/snoop_fwd.sv \
      source/cluster_mem.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module cluster_mem $(RTL)
	verilator --lint-only --timing --top-module tb_cluster_mem -f sim.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_cluster_mem \
		-f sim.f -Mdir obj_dir -o tb_cluster_mem
	./obj_dir/tb_cluster_mem | tee sim.log
	grep -qx "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_cluster_checks.svh ====
`ifndef TB_CLUSTER_CHECKS_SVH
`define TB_CLUSTER_CHECKS_SVH

// Initial content of a line nobody has written
function automatic line_data_t line_pattern(input line_addr_t addr);
    logic [31:0] a;
    a = {6'h2d, addr};
    return {a ^ 32'hdead_beef, ~a, a * 32'h9e37_79b9, {a[15:0], a[31:16]}};
endfunction

// Line content as the cores have written it so far
function automatic line_data_t ref_data(input line_addr_t addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : line_pattern(addr);
endfunction

// Each channel owns the address region given by the top bits
function automatic line_addr_t make_addr(input int ch, input int offset);
    return {REGION_BITS'(ch), (ADDR_WIDTH - REGION_BITS)'(offset)};
endfunction

// Core index on top, then the channel bit, then the core tag
function automatic dram_tag_t dram_tag_for(input int ch, input core_tag_t tag);
    return {CORE_SEL_BITS'(ch / 2), 1'(ch % 2), tag};
endfunction

task automatic check_rsp(input string name, input core_rsp_t exp, input core_rsp_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_dram_tag(input string name, input dram_tag_t exp, input dram_tag_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

// Write flag, address and data; the tag has its own check
task automatic check_dram_req(input string name, input dram_req_t exp, input dram_req_t act);
    checks++;
    if ({act.write, act.addr, act.data} !== {exp.write, exp.addr, exp.data}) begin
        errors++;
        $display("FAILED %s: expected %h, actual %h", name,
                 {exp.write, exp.addr, exp.data}, {act.write, act.addr, act.data});
    end
endtask

task automatic check_snoop(input string name, input line_addr_t exp, input line_addr_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

`endif

// ==== testbench/tb_cluster_mem.sv ====
`timescale 1ns/1ps

module tb_cluster_mem;
    import cluster_mem_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_CHANNELS = 2 * NUM_CORES;
    localparam int REGION_BITS  = 2;
    localparam int NUM_TAGS     = 2 ** CORE_TAG_WIDTH;
    localparam int STRESS_COUNT = 40;
    localparam int BURST_COUNT  = 8;
    localparam int TOTAL_TXNS   = NUM_CHANNELS * (STRESS_COUNT + BURST_COUNT) + 8 + 2;

    logic                         clk = 1'b0;
    logic                         rst = 1'b1;
    logic [NUM_CORES-1:0]         dreq_valid = '0;
    dcache_req_t [NUM_CORES-1:0]  dreq = '0;
    logic [NUM_CORES-1:0]         dreq_ready;
    logic [NUM_CORES-1:0]         ireq_valid = '0;
    icache_req_t [NUM_CORES-1:0]  ireq = '0;
    logic [NUM_CORES-1:0]         ireq_ready;
    logic [NUM_CORES-1:0]         drsp_valid;
    core_rsp_t [NUM_CORES-1:0]    drsp;
    logic [NUM_CORES-1:0]         drsp_ready = '0;
    logic [NUM_CORES-1:0]         irsp_valid;
    core_rsp_t [NUM_CORES-1:0]    irsp;
    logic [NUM_CORES-1:0]         irsp_ready = '0;
    logic                         dram_req_valid;
    dram_req_t                    dram_req;
    logic                         dram_req_ready = 1'b0;
    logic                         dram_rsp_valid = 1'b0;
    dram_rsp_t                    dram_rsp = '0;
    logic                         dram_rsp_ready;
    logic                         llc_snp_req_valid = 1'b0;
    line_addr_t                   llc_snp_req_addr = '0;
    logic                         llc_snp_req_ready;
    logic                         snp_fwd_valid;
    line_addr_t                   snp_fwd_addr;
    logic [NUM_CORES-1:0]         snp_fwd_ready = '0;

    int seed = 19;
    int errors = 0;
    int checks = 0;
    int outstanding = 0;
    int req_ready_pct = 100;
    int rsp_pct = 100;
    int core_ready_pct = 100;
    logic rsp_taken = 1'b0;
    logic log_order = 1'b0;
    logic [NUM_TAGS-1:0] busy [NUM_CHANNELS] = '{default: '0};
    core_tag_t  next_tag [NUM_CHANNELS] = '{default: '0};
    core_rsp_t  exp_rsp [NUM_CHANNELS][NUM_TAGS];
    dram_req_t  issued [NUM_CHANNELS][$];
    dram_rsp_t  pend [$];
    dram_tag_t  order_log [$];
    line_data_t ref_mem [line_addr_t];
    line_data_t dram_mem [line_addr_t];

    `include "tb_cluster_checks.svh"

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic line_data_t random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    cluster_mem cluster_mem_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Leaves valid high after the accepting edge
    task automatic send(input int ch, input logic write, input int offset, input line_data_t data);
        int         c;
        logic       instr;
        core_tag_t  tag;
        line_addr_t addr;
        dram_req_t  exp;
        c = ch / 2;
        instr = (ch % 2) == 1;
        addr = make_addr(ch, offset);
        @(negedge clk);
        while (busy[ch][next_tag[ch]]) begin
            if (instr) ireq_valid[c] = 1'b0;
            else dreq_valid[c] = 1'b0;
            @(negedge clk);
        end
        tag = next_tag[ch];
        next_tag[ch] = tag + 1'b1;
        exp.write = write && !instr;
        exp.addr = addr;
        exp.data = instr ? '0 : data;
        exp.tag = dram_tag_for(ch, tag);
        issued[ch].push_back(exp);
        if (exp.write) begin
            ref_mem[addr] = data;
        end else begin
            busy[ch][tag] = 1'b1;
            outstanding++;
            exp_rsp[ch][tag].data = ref_data(addr);
            exp_rsp[ch][tag].tag = tag;
        end
        if (instr) begin
            ireq_valid[c] = 1'b1;
            ireq[c] = '{addr: addr, tag: tag};
        end else begin
            dreq_valid[c] = 1'b1;
            dreq[c] = '{write: write, addr: addr, data: data, tag: tag};
        end
        do @(posedge clk); while (!(instr ? ireq_ready[c] : dreq_ready[c]));
    endtask

    task automatic release_channel(input int ch);
        @(negedge clk);
        if (ch % 2 == 1) ireq_valid[ch / 2] = 1'b0;
        else dreq_valid[ch / 2] = 1'b0;
    endtask

    task automatic run_stream(input int ch, input int count, input int gap_max);
        int   gap;
        logic write;
        for (int i = 0; i < count; i++) begin
            write = (ch % 2 == 0) && (random_below(3) == 0);
            send(ch, write, random_below(8), random_line());
            gap = random_below(gap_max + 1);
            if (gap > 0) begin
                release_channel(ch);
                repeat (gap - 1) @(negedge clk);
            end
        end
        release_channel(ch);
    endtask

    task automatic wait_drained();
        int left;
        forever begin
            left = outstanding;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) left += issued[ch].size();
            if (left == 0) break;
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic check_alternation();
        logic seen [NUM_CORES];
        logic last_chan [NUM_CORES];
        int   core;
        if (order_log.size() != NUM_CHANNELS * BURST_COUNT) begin
            errors++;
            $display("ERROR: burst produced %0d DRAM requests", order_log.size());
        end
        for (int c = 0; c < NUM_CORES; c++) seen[c] = 1'b0;
        for (int k = 0; k < order_log.size(); k++) begin
            core = int'(order_log[k][DRAM_TAG_WIDTH-1 -: CORE_SEL_BITS]);
            if (k > 0 && core == int'(order_log[k-1][DRAM_TAG_WIDTH-1 -: CORE_SEL_BITS])) begin
                errors++;
                $display("ERROR: core %0d won DRAM twice in a row at request %0d", core, k);
            end
            if (seen[core] && last_chan[core] == order_log[k][CORE_TAG_WIDTH]) begin
                errors++;
                $display("ERROR: core %0d sent one channel twice in a row at request %0d",
                         core, k);
            end
            seen[core] = 1'b1;
            last_chan[core] = order_log[k][CORE_TAG_WIDTH];
        end
    endtask

    task automatic run_snoop(input line_addr_t addr);
        int                   delay [NUM_CORES];
        logic [NUM_CORES-1:0] acked;
        int                   cycle;
        acked = '0;
        cycle = 0;
        for (int c = 0; c < NUM_CORES; c++) delay[c] = random_below(8);
        @(negedge clk);
        llc_snp_req_valid = 1'b1;
        llc_snp_req_addr = addr;
        do @(posedge clk); while (!llc_snp_req_ready);
        @(negedge clk);
        llc_snp_req_valid = 1'b0;
        while (acked != '1) begin
            for (int c = 0; c < NUM_CORES; c++) snp_fwd_ready[c] = (cycle == delay[c]);
            @(posedge clk);
            check_snoop("snoop broadcast", addr, snp_fwd_addr);
            if (!snp_fwd_valid || llc_snp_req_ready) begin
                errors++;
                $display("ERROR: snoop ended before every core acknowledged");
            end
            acked |= snp_fwd_ready;
            @(negedge clk);
            cycle++;
        end
        snp_fwd_ready = '0;
        @(posedge clk);
        if (snp_fwd_valid || !llc_snp_req_ready) begin
            errors++;
            $display("ERROR: snoop still in flight after every core acknowledged");
        end
    endtask

    // DRAM side: checks each request, then stores writes or queues reads
    always @(posedge clk) begin : dram_model
        int        ch;
        dram_req_t exp;
        dram_rsp_t rd;
        rsp_taken <= dram_rsp_valid && dram_rsp_ready;
        if (!rst && dram_req_valid && dram_req_ready) begin
            ch = int'(dram_req.addr[ADDR_WIDTH-1 -: REGION_BITS]);
            if (log_order) order_log.push_back(dram_req.tag);
            if (issued[ch].size() == 0) begin
                errors++;
                $display("ERROR: DRAM request to %h that no core issued", dram_req.addr);
            end else begin
                exp = issued[ch].pop_front();
                check_dram_tag($sformatf("dram tag ch%0d", ch), exp.tag, dram_req.tag);
                check_dram_req($sformatf("dram request ch%0d", ch), exp, dram_req);
            end
            if (dram_req.write) begin
                dram_mem[dram_req.addr] = dram_req.data;
            end else begin
                rd.data = dram_mem.exists(dram_req.addr) ? dram_mem[dram_req.addr]
                                                         : line_pattern(dram_req.addr);
                rd.tag = dram_req.tag;
                pend.push_back(rd);
            end
        end
    end

    // Responses leave in random order after random gaps
    always @(negedge clk) begin : dram_driver
        int idx;
        if (rsp_taken) dram_rsp_valid = 1'b0;
        if (!dram_rsp_valid && pend.size() != 0 && random_below(100) < rsp_pct) begin
            idx = random_below(pend.size());
            dram_rsp = pend[idx];
            pend.delete(idx);
            dram_rsp_valid = 1'b1;
        end
        dram_req_ready = random_below(100) < req_ready_pct;
        for (int c = 0; c < NUM_CORES; c++) begin
            drsp_ready[c] = random_below(100) < core_ready_pct;
            irsp_ready[c] = random_below(100) < core_ready_pct;
        end
    end

    always @(posedge clk) begin : rsp_monitor
        int        ch;
        logic      taken;
        core_rsp_t rsp;
        if (!rst) begin
            for (int c = 0; c < NUM_CORES; c++) begin
                for (int i = 0; i < 2; i++) begin
                    ch = 2 * c + i;
                    taken = (i == 1) ? (irsp_valid[c] && irsp_ready[c])
                                     : (drsp_valid[c] && drsp_ready[c]);
                    rsp = (i == 1) ? irsp[c] : drsp[c];
                    if (taken && !busy[ch][rsp.tag]) begin
                        errors++;
                        $display("ERROR: response on channel %0d with tag %0d that no read awaits",
                                 ch, rsp.tag);
                    end else if (taken) begin
                        check_rsp($sformatf("response ch%0d tag %0d", ch, rsp.tag),
                                  exp_rsp[ch][rsp.tag], rsp);
                        busy[ch][rsp.tag] = 1'b0;
                        outstanding--;
                    end
                end
            end
        end
    end

    initial begin : main
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (dram_req_valid || (|drsp_valid) || (|irsp_valid) || snp_fwd_valid
            || !llc_snp_req_ready) begin
            errors++;
            $display("ERROR: outputs not idle after reset");
        end
        // Plain reads, then a write and a read of the same line per core
        for (int c = 0; c < NUM_CORES; c++) begin
            send(2 * c, 1'b0, 'h10 + c, '0);
            release_channel(2 * c);
            send(2 * c + 1, 1'b0, 'h20, '0);
            release_channel(2 * c + 1);
            send(2 * c, 1'b1, 'h30, random_line());
            send(2 * c, 1'b0, 'h30, '0);
            release_channel(2 * c);
        end
        wait_drained();
        req_ready_pct = 70;
        rsp_pct = 50;
        core_ready_pct = 70;
        fork
            run_stream(0, STRESS_COUNT, 3);
            run_stream(1, STRESS_COUNT, 3);
            run_stream(2, STRESS_COUNT, 3);
            run_stream(3, STRESS_COUNT, 3);
        join
        wait_drained();
        // Back-to-back burst with DRAM always ready
        req_ready_pct = 100;
        rsp_pct = 100;
        core_ready_pct = 100;
        log_order = 1'b1;
        fork
            run_stream(0, BURST_COUNT, 0);
            run_stream(1, BURST_COUNT, 0);
            run_stream(2, BURST_COUNT, 0);
            run_stream(3, BURST_COUNT, 0);
        join
        wait_drained();
        log_order = 1'b0;
        check_alternation();
        run_snoop(line_addr_t'($random(seed)));
        run_snoop(line_addr_t'($random(seed)));
        finish_run();
    end

    initial begin : watchdog
        #(TOTAL_TXNS * 200 * CLK_PERIOD);
        errors++;
        $display("ERROR: timeout with %0d reads still missing a response", outstanding);
        finish_run();
    end

endmodule

// ==== source/cluster_mem.sv ====
`timescale 1ns/1ps

module cluster_mem (
    input  logic                                  clk,
    input  logic                                  rst,

    // Data cache requests
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] dreq_valid,
    input  cluster_mem_pkg::dcache_req_t [cluster_mem_pkg::NUM_CORES-1:0] dreq,
    output logic [cluster_mem_pkg::NUM_CORES-1:0] dreq_ready,

    // Instruction cache requests
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] ireq_valid,
    input  cluster_mem_pkg::icache_req_t [cluster_mem_pkg::NUM_CORES-1:0] ireq,
    output logic [cluster_mem_pkg::NUM_CORES-1:0] ireq_ready,

    // Core responses
    output logic [cluster_mem_pkg::NUM_CORES-1:0] drsp_valid,
    output cluster_mem_pkg::core_rsp_t [cluster_mem_pkg::NUM_CORES-1:0] drsp,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] drsp_ready,
    output logic [cluster_mem_pkg::NUM_CORES-1:0] irsp_valid,
    output cluster_mem_pkg::core_rsp_t [cluster_mem_pkg::NUM_CORES-1:0] irsp,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] irsp_ready,

    // DRAM
    output logic                                  dram_req_valid,
    output cluster_mem_pkg::dram_req_t            dram_req,
    input  logic                                  dram_req_ready,
    input  logic                                  dram_rsp_valid,
    input  cluster_mem_pkg::dram_rsp_t            dram_rsp,
    output logic                                  dram_rsp_ready,

    // Snooping
    input  logic                                  llc_snp_req_valid,
    input  cluster_mem_pkg::line_addr_t           llc_snp_req_addr,
    output logic                                  llc_snp_req_ready,
    output logic                                  snp_fwd_valid,
    output cluster_mem_pkg::line_addr_t           snp_fwd_addr,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] snp_fwd_ready
);
    import cluster_mem_pkg::*;

    logic [NUM_CORES-1:0]        merged_valid;
    merged_req_t [NUM_CORES-1:0] merged_req;
    logic [NUM_CORES-1:0]        merged_ready;

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_merge
        core_req_merge merge_i (
            .clk        (clk),
            .rst        (rst),
            .dreq_valid (dreq_valid[c]),
            .dreq       (dreq[c]),
            .dreq_ready (dreq_ready[c]),
            .ireq_valid (ireq_valid[c]),
            .ireq       (ireq[c]),
            .ireq_ready (ireq_ready[c]),
            .out_valid  (merged_valid[c]),
            .out_req    (merged_req[c]),
            .out_ready  (merged_ready[c])
        );
    end

    dram_req_arb arb_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (merged_valid),
        .in_req         (merged_req),
        .in_ready       (merged_ready),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready)
    );

    dram_rsp_route route_i (
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .drsp_valid     (drsp_valid),
        .irsp_valid     (irsp_valid),
        .rsp            (drsp),
        .drsp_ready     (drsp_ready),
        .irsp_ready     (irsp_ready)
    );

    // Both channels see the same payload, valids tell them apart
    assign irsp = drsp;

    snoop_fwd snoop_i (
        .clk           (clk),
        .rst           (rst),
        .snp_req_valid (llc_snp_req_valid),
        .snp_req_addr  (llc_snp_req_addr),
        .snp_req_ready (llc_snp_req_ready),
        .snp_fwd_valid (snp_fwd_valid),
        .snp_fwd_addr  (snp_fwd_addr),
        .snp_fwd_ready (snp_fwd_ready)
    );

endmodule

// ==== source/snoop_fwd.sv ====
`timescale 1ns/1ps

module snoop_fwd (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  snp_req_valid,
    input  cluster_mem_pkg::line_addr_t           snp_req_addr,
    output logic                                  snp_req_ready,
    output logic                                  snp_fwd_valid,
    output cluster_mem_pkg::line_addr_t           snp_fwd_addr,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] snp_fwd_ready
);
    import cluster_mem_pkg::*;

    logic                 in_flight;
    logic [NUM_CORES-1:0] ack_mask;
    logic [NUM_CORES-1:0] ack_next;
    logic                 all_acked;
    line_addr_t           addr_q;

    // Acks seen so far, this cycle included
    assign ack_next      = ack_mask | snp_fwd_ready;
    assign all_acked     = &ack_next;
    assign snp_req_ready = !in_flight;
    assign snp_fwd_valid = in_flight;
    assign snp_fwd_addr  = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
            ack_mask  <= '0;
        end else if (!in_flight) begin
            in_flight <= snp_req_valid;
        end else if (all_acked) begin
            in_flight <= 1'b0;
            ack_mask  <= '0;
        end else begin
            ack_mask <= ack_next;
        end
    end

    always_ff @(posedge clk) begin
        if (snp_req_valid && snp_req_ready) begin
            addr_q <= snp_req_addr;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (in_flight && !all_acked) |=> (snp_fwd_valid && $stable(snp_fwd_addr)))
        else $error("snoop_fwd: broadcast address changed in flight");

endmodule

// ==== source/dram_rsp_route.sv ====
`timescale 1ns/1ps

module dram_rsp_route (
    input  logic                                 dram_rsp_valid,
    input  cluster_mem_pkg::dram_rsp_t           dram_rsp,
    output logic                                 dram_rsp_ready,
    output logic [cluster_mem_pkg::NUM_CORES-1:0] drsp_valid,
    output logic [cluster_mem_pkg::NUM_CORES-1:0] irsp_valid,
    output cluster_mem_pkg::core_rsp_t [cluster_mem_pkg::NUM_CORES-1:0] rsp,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] drsp_ready,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0] irsp_ready
);
    import cluster_mem_pkg::*;

    logic [CORE_SEL_BITS-1:0] core_idx;
    logic                     chan;
    core_tag_t                core_tag;

    // Tag layout is core index, channel bit, core tag
    assign core_idx = dram_rsp.tag[DRAM_TAG_WIDTH-1 -: CORE_SEL_BITS];
    assign chan     = dram_rsp.tag[CORE_TAG_WIDTH];
    assign core_tag = dram_rsp.tag[CORE_TAG_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            rsp[i].data   = dram_rsp.data;
            rsp[i].tag    = core_tag;
            drsp_valid[i] = dram_rsp_valid && (int'(core_idx) == i) && (chan == CHAN_DATA);
            irsp_valid[i] = dram_rsp_valid && (int'(core_idx) == i) && (chan == CHAN_INSTR);
        end
    end

    // Only the addressed channel can stall DRAM
    assign dram_rsp_ready = (chan == CHAN_INSTR) ? irsp_ready[core_idx]
                                                 : drsp_ready[core_idx];

    always_comb begin
        a_core_range: assert (!dram_rsp_valid || (int'(core_idx) < NUM_CORES))
            else $error("dram_rsp_route: response for core %0d", core_idx);
    end

endmodule

// ==== source/dram_req_arb.sv ====
`timescale 1ns/1ps

module dram_req_arb (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [cluster_mem_pkg::NUM_CORES-1:0]  in_valid,
    input  cluster_mem_pkg::merged_req_t [cluster_mem_pkg::NUM_CORES-1:0] in_req,
    output logic [cluster_mem_pkg::NUM_CORES-1:0]  in_ready,
    output logic                                   dram_req_valid,
    output cluster_mem_pkg::dram_req_t             dram_req,
    input  logic                                   dram_req_ready
);
    import cluster_mem_pkg::*;

    logic [CORE_SEL_BITS-1:0] rr_ptr;
    logic [CORE_SEL_BITS-1:0] grant_idx;
    logic                     grant_any;
    logic                     fifo_in_ready;
    dram_req_t                fifo_in;

    // First valid core at or after the round-robin pointer
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = rr_ptr;
        for (int i = NUM_CORES - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_CORES;
            if (in_valid[idx]) begin
                grant_any = 1'b1;
                grant_idx = CORE_SEL_BITS'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            in_ready[i] = grant_any && fifo_in_ready && (int'(grant_idx) == i);
        end
    end

    // Core index goes on top of the tag
    always_comb begin
        fifo_in.write = in_req[grant_idx].write;
        fifo_in.addr  = in_req[grant_idx].addr;
        fifo_in.data  = in_req[grant_idx].data;
        fifo_in.tag   = {grant_idx, in_req[grant_idx].tag};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (grant_any && fifo_in_ready) begin
            rr_ptr <= (int'(grant_idx) == NUM_CORES - 1) ? '0 : grant_idx + 1'b1;
        end
    end

    mem_fifo #(
        .T     (dram_req_t),
        .DEPTH (REQ_FIFO_DEPTH)
    ) req_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (grant_any),
        .in_data   (fifo_in),
        .in_ready  (fifo_in_ready),
        .out_valid (dram_req_valid),
        .out_data  (dram_req),
        .out_ready (dram_req_ready)
    );

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(in_valid & in_ready))
        else $error("dram_req_arb: more than one core granted");

endmodule

// ==== source/core_req_merge.sv ====
`timescale 1ns/1ps

module core_req_merge (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dreq_valid,
    input  cluster_mem_pkg::dcache_req_t  dreq,
    output logic                          dreq_ready,
    input  logic                          ireq_valid,
    input  cluster_mem_pkg::icache_req_t  ireq,
    output logic                          ireq_ready,
    output logic                          out_valid,
    output cluster_mem_pkg::merged_req_t  out_req,
    input  logic                          out_ready
);
    import cluster_mem_pkg::*;

    logic instr_first;
    logic sel_instr;

    // Instruction wins when alone or when it holds priority
    assign sel_instr  = ireq_valid && (!dreq_valid || instr_first);
    assign out_valid  = dreq_valid || ireq_valid;
    assign dreq_ready = out_ready && !sel_instr;
    assign ireq_ready = out_ready && sel_instr;

    always_comb begin
        if (sel_instr) begin
            out_req.write = 1'b0;
            out_req.addr  = ireq.addr;
            out_req.data  = '0;
            out_req.tag   = {CHAN_INSTR, ireq.tag};
        end else begin
            out_req.write = dreq.write;
            out_req.addr  = dreq.addr;
            out_req.data  = dreq.data;
            out_req.tag   = {CHAN_DATA, dreq.tag};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_first <= 1'b0;
        end else if (out_valid && out_ready) begin
            // Other channel goes first next time
            instr_first <= !sel_instr;
        end
    end

endmodule

// ==== source/mem_fifo.sv ====
`timescale 1ns/1ps

module mem_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,
    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_BITS:0]   FULL_COUNT = (PTR_BITS + 1)'(DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_SLOT  = PTR_BITS'(DEPTH - 1);

    T                    mem [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS:0]   count;
    logic                full;
    logic                push;
    logic                pop;

    assign full      = (count == FULL_COUNT);
    assign out_valid = (count != '0);
    // Full queue still takes an entry when the head leaves
    assign in_ready  = !full || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Overflow or underflow would push count out of range
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        count <= FULL_COUNT)
        else $error("mem_fifo: occupancy out of range");

    a_head_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("mem_fifo: head changed while stalled");

endmodule

// ==== source/cluster_mem_pkg.sv ====
package cluster_mem_pkg;

    localparam int NUM_CORES      = 2;
    localparam int CORE_SEL_BITS  = 1;
    localparam int ADDR_WIDTH     = 26;
    localparam int LINE_WIDTH     = 128;
    localparam int CORE_TAG_WIDTH = 4;
    // Core tag with the channel bit on top
    localparam int CHAN_TAG_WIDTH = CORE_TAG_WIDTH + 1;
    localparam int DRAM_TAG_WIDTH = CORE_SEL_BITS + CHAN_TAG_WIDTH;
    localparam int REQ_FIFO_DEPTH = 4;

    // Channel bit encoding
    localparam logic CHAN_DATA  = 1'b0;
    localparam logic CHAN_INSTR = 1'b1;

    typedef logic [ADDR_WIDTH-1:0]     line_addr_t;
    typedef logic [LINE_WIDTH-1:0]     line_data_t;
    typedef logic [CORE_TAG_WIDTH-1:0] core_tag_t;
    typedef logic [CHAN_TAG_WIDTH-1:0] chan_tag_t;
    typedef logic [DRAM_TAG_WIDTH-1:0] dram_tag_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_data_t data;
        core_tag_t  tag;
    } dcache_req_t;

    typedef struct packed {
        line_addr_t addr;
        core_tag_t  tag;
    } icache_req_t;

    typedef struct packed {
        line_data_t data;
        core_tag_t  tag;
    } core_rsp_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_data_t data;
        chan_tag_t  tag;
    } merged_req_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_data_t data;
        dram_tag_t  tag;
    } dram_req_t;

    typedef struct packed {
        line_data_t data;
        dram_tag_t  tag;
    } dram_rsp_t;

endpackage
